// ==== common/ctxmgt_pkg.sv ====
// qpn fields are carried 32 bits wide but only the low QPN_W bits address the table
package ctxmgt_pkg;

    // ------------------------------------------------------------------------
    // widths and plain vector types
    // ------------------------------------------------------------------------
    localparam int QPN_W_DEF = 8;       // default table index width

    typedef logic [63:0] ctx_t;         // one key context word
    typedef logic [7:0]  tag_t;         // requester tag, echoed back
    typedef logic [31:0] qpn_t;         // full queue pair number field

    // ceu opcodes, codes 0 and 3 are reserved
    typedef enum logic [1:0] {
        CEU_RSVD0   = 2'd0,
        CEU_WR_CTX  = 2'd1,             // write given context
        CEU_CLR_CTX = 2'd2,             // write zero
        CEU_RSVD3   = 2'd3
    } ceu_op_e;

    // ------------------------------------------------------------------------
    // channel payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        ceu_op_e op;
        qpn_t    qpn;
        ctx_t    ctx;
    } ceu_req_t;                        // 98 bits

    typedef struct packed {
        qpn_t    qpn;
        ceu_op_e op;
    } ceu_cpl_t;                        // one per table write

    typedef struct packed {
        tag_t tag;
        qpn_t qpn;
    } eng_cmd_t;                        // engine read command

    typedef struct packed {
        tag_t tag;
        qpn_t qpn;
        ctx_t ctx;
    } eng_rsp_t;                        // engine read response

    typedef struct packed {
        qpn_t    qpn;
        ctx_t    ctx;
        ceu_op_e op;
    } key_wr_t;                         // ceu write queue entry

    // requester slots, shared by scheduler, table and top
    localparam int NUM_REQ = 3;
    localparam int REQ_CEU = 0;
    localparam int REQ_DB  = 1;
    localparam int REQ_WP  = 2;

    // table fsm
    typedef enum logic [1:0] {
        IDLE,
        POP,
        ACCESS,
        ISSUE
    } tbl_state_e;

endpackage

// ==== key_ctx/key_ctx_ram.sv ====
// contents are undefined until the table's clear sweep has run
`timescale 1ns/10ps

module key_ctx_ram #(
    parameter int QPN_W = ctxmgt_pkg::QPN_W_DEF
) (
    input  logic                 clk,
    input  logic                 i_we,
    input  logic [QPN_W-1:0]     i_addr,
    input  ctxmgt_pkg::ctx_t     i_wdata,
    output ctxmgt_pkg::ctx_t     o_rdata
);

    localparam int DEPTH = 2 ** QPN_W;

    ctxmgt_pkg::ctx_t mem [DEPTH];   // one context per qp

    // single port, one cycle read
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
            o_rdata     <= i_wdata;      // write first
        end else begin
            o_rdata     <= mem[i_addr];
        end
    end

endmodule

// ==== key_ctx/key_ctx_table.sv ====
// one request in flight; QPN_W must not exceed 32, upper qpn bits are ignored
`timescale 1ns/10ps

module key_ctx_table #(
    parameter int QPN_W = ctxmgt_pkg::QPN_W_DEF
) (
    input  logic                            clk,
    input  logic                            rst,
    output logic                            o_init_finish,
    input  logic [ctxmgt_pkg::NUM_REQ-1:0]  i_sel,
    input  logic                            i_sel_valid,
    output logic                            o_receive,
    input  ctxmgt_pkg::key_wr_t             i_kw_data,
    output logic                            o_kw_rd_en,
    input  logic                            i_db_cmd_empty,
    input  ctxmgt_pkg::eng_cmd_t            i_db_cmd,
    output logic                            o_db_cmd_rd_en,
    input  logic                            i_db_rsp_prog_full,
    output logic                            o_db_rsp_wr_en,
    output ctxmgt_pkg::eng_rsp_t            o_db_rsp,
    input  logic                            i_wp_cmd_empty,
    input  ctxmgt_pkg::eng_cmd_t            i_wp_cmd,
    output logic                            o_wp_cmd_rd_en,
    input  logic                            i_wp_rsp_prog_full,
    output logic                            o_wp_rsp_wr_en,
    output ctxmgt_pkg::eng_rsp_t            o_wp_rsp,
    output logic                            o_cpl_valid,
    output ctxmgt_pkg::ceu_cpl_t            o_cpl,
    input  logic                            i_cpl_ready
);

    ctxmgt_pkg::tbl_state_e          state;
    logic [QPN_W:0]                  init_cnt;    // msb set = sweep done
    logic                            clear_we;
    logic [ctxmgt_pkg::NUM_REQ-1:0]  cur_src;     // one-hot owner of the request
    ctxmgt_pkg::qpn_t                cur_qpn;
    ctxmgt_pkg::tag_t                cur_tag;
    ctxmgt_pkg::ctx_t                cur_ctx;
    ctxmgt_pkg::ceu_op_e             cur_op;
    logic                            ram_we;
    logic [QPN_W-1:0]                ram_addr;
    ctxmgt_pkg::ctx_t                ram_wdata;
    ctxmgt_pkg::ctx_t                ram_rdata;
    ctxmgt_pkg::eng_rsp_t            rsp;
    logic                            issue_done;

    // ------------------------------------------------------------------------
    // clear sweep, zero every entry once after reset
    // ------------------------------------------------------------------------
    assign clear_we = !init_cnt[QPN_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_cnt      <= '0;
            o_init_finish <= 1'b0;
        end else begin
            if (clear_we) init_cnt <= init_cnt + 1'b1;
            o_init_finish <= init_cnt[QPN_W];   // one cycle after last write
        end
    end

    // ------------------------------------------------------------------------
    // ram port, sweep owns it until done
    // ------------------------------------------------------------------------
    assign ram_we    = clear_we || ((state == ctxmgt_pkg::ACCESS) && cur_src[ctxmgt_pkg::REQ_CEU]);
    assign ram_addr  = clear_we ? init_cnt[QPN_W-1:0] : cur_qpn[QPN_W-1:0];
    assign ram_wdata = clear_we ? '0 : cur_ctx;

    key_ctx_ram #(.QPN_W(QPN_W)) u_key_ctx_ram (
        .clk     (clk),
        .i_we    (ram_we),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)     // stable through ISSUE, addr held
    );

    // ------------------------------------------------------------------------
    // request fsm
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ctxmgt_pkg::IDLE;
            cur_src <= '0;
        end else begin
            case (state)
                ctxmgt_pkg::IDLE: if (o_init_finish && i_sel_valid) begin
                    cur_src <= i_sel;
                    state   <= ctxmgt_pkg::POP;
                end
                ctxmgt_pkg::POP:    state <= ctxmgt_pkg::ACCESS;
                ctxmgt_pkg::ACCESS: state <= ctxmgt_pkg::ISSUE;
                ctxmgt_pkg::ISSUE:  if (issue_done) state <= ctxmgt_pkg::IDLE;
                default:            state <= ctxmgt_pkg::IDLE;
            endcase
        end
    end

    // capture popped word, fifo data valid alongside rd_en
    always_ff @(posedge clk) begin
        if (state == ctxmgt_pkg::POP) begin
            if (cur_src[ctxmgt_pkg::REQ_CEU]) begin
                cur_qpn <= i_kw_data.qpn;
                cur_ctx <= i_kw_data.ctx;
                cur_op  <= i_kw_data.op;
            end else if (cur_src[ctxmgt_pkg::REQ_DB]) begin
                cur_qpn <= i_db_cmd.qpn;
                cur_tag <= i_db_cmd.tag;
            end else begin
                cur_qpn <= i_wp_cmd.qpn;
                cur_tag <= i_wp_cmd.tag;
            end
        end
    end

    // pops, one cycle each
    assign o_receive      = (state == ctxmgt_pkg::POP);
    assign o_kw_rd_en     = o_receive && cur_src[ctxmgt_pkg::REQ_CEU];
    assign o_db_cmd_rd_en = o_receive && cur_src[ctxmgt_pkg::REQ_DB];
    assign o_wp_cmd_rd_en = o_receive && cur_src[ctxmgt_pkg::REQ_WP];

    // ------------------------------------------------------------------------
    // issue, waits on prog_full or cpl ready
    // ------------------------------------------------------------------------
    assign rsp = '{tag: cur_tag, qpn: cur_qpn, ctx: ram_rdata};
    assign o_db_rsp = rsp;
    assign o_wp_rsp = rsp;

    assign o_db_rsp_wr_en = (state == ctxmgt_pkg::ISSUE) && cur_src[ctxmgt_pkg::REQ_DB] &&
                            !i_db_rsp_prog_full;
    assign o_wp_rsp_wr_en = (state == ctxmgt_pkg::ISSUE) && cur_src[ctxmgt_pkg::REQ_WP] &&
                            !i_wp_rsp_prog_full;
    assign o_cpl_valid    = (state == ctxmgt_pkg::ISSUE) && cur_src[ctxmgt_pkg::REQ_CEU];
    assign o_cpl          = '{qpn: cur_qpn, op: cur_op};

    assign issue_done = o_db_rsp_wr_en || o_wp_rsp_wr_en || (o_cpl_valid && i_cpl_ready);

    a_no_wr_full: assert property (@(posedge clk) disable iff (rst)
        !(o_db_rsp_wr_en && i_db_rsp_prog_full) && !(o_wp_rsp_wr_en && i_wp_rsp_prog_full))
        else $error("response written while prog_full");

    // sweep must own the ram until every entry is cleared
    a_no_early_pop: assert property (@(posedge clk) disable iff (rst)
        (o_kw_rd_en || o_db_cmd_rd_en || o_wp_cmd_rd_en) |-> o_init_finish)
        else $error("command popped before init finished");

endmodule

// ==== hdl/ceu_parser.sv ====
// reserved opcodes are taken off the bus and dropped, so they never get a completion
`timescale 1ns/10ps

module ceu_parser (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_init_finish,
    input  logic                  i_ceu_valid,
    input  ctxmgt_pkg::ceu_req_t  i_ceu_req,
    output logic                  o_ceu_ready,
    input  logic                  i_kw_rd_en,
    output logic                  o_kw_empty,
    output ctxmgt_pkg::key_wr_t   o_kw_data
);

    localparam int DEPTH = 4;
    localparam int PTR_W = 2;

    ctxmgt_pkg::key_wr_t mem [DEPTH];   // key write queue
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      count;         // 0..DEPTH
    logic                xfer;          // bus handshake
    logic                is_key_op;     // wr or clr
    logic                push;
    ctxmgt_pkg::key_wr_t wr_entry;

    // ------------------------------------------------------------------------
    // opcode decode
    // ------------------------------------------------------------------------
    assign is_key_op = (i_ceu_req.op == ctxmgt_pkg::CEU_WR_CTX) ||
                       (i_ceu_req.op == ctxmgt_pkg::CEU_CLR_CTX);

    always_comb begin
        wr_entry.qpn = i_ceu_req.qpn;
        wr_entry.op  = i_ceu_req.op;
        // clear is turned into a zero write here, table just writes ctx
        wr_entry.ctx = (i_ceu_req.op == ctxmgt_pkg::CEU_CLR_CTX) ? '0 : i_ceu_req.ctx;
    end

    assign o_ceu_ready = i_init_finish && (count != (PTR_W+1)'(DEPTH));  // no room, no ready
    assign xfer        = i_ceu_valid && o_ceu_ready;
    assign push        = xfer && is_key_op;   // reserved codes end here

    // ------------------------------------------------------------------------
    // queue
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (i_kw_rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({push, i_kw_rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or none
            endcase
        end
    end

    assign o_kw_empty = (count == '0);
    assign o_kw_data  = mem[rd_ptr];      // fall-through head

    // table pops only what the scheduler saw as non-empty
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        i_kw_rd_en |-> !o_kw_empty)
        else $error("ceu key queue popped while empty");

endmodule

// ==== hdl/req_sched.sv ====
// selection stays put until the table pulses receive, empties are not sampled again
`timescale 1ns/10ps

module req_sched (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_init_finish,
    input  logic [ctxmgt_pkg::NUM_REQ-1:0]   i_empty,
    input  logic                             i_receive,
    output logic [ctxmgt_pkg::NUM_REQ-1:0]   o_sel,
    output logic                             o_sel_valid
);

    localparam int IDX_W = $clog2(ctxmgt_pkg::NUM_REQ);

    logic [IDX_W-1:0]               last_idx;   // last granted requester
    logic [IDX_W-1:0]               nxt_idx;
    logic [ctxmgt_pkg::NUM_REQ-1:0] nxt_sel;

    // ------------------------------------------------------------------------
    // round robin pick, nearest non-empty after last grant wins
    // ------------------------------------------------------------------------
    always_comb begin
        int idx;
        nxt_sel = '0;
        nxt_idx = last_idx;
        // walk from farthest to nearest so nearest overrides
        for (int i = ctxmgt_pkg::NUM_REQ; i >= 1; i--) begin
            idx = (int'(last_idx) + i) % ctxmgt_pkg::NUM_REQ;
            if (!i_empty[idx]) begin
                nxt_sel      = '0;
                nxt_sel[idx] = 1'b1;
                nxt_idx      = IDX_W'(idx);
            end
        end
    end

    // ------------------------------------------------------------------------
    // held selection
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_sel       <= '0;
            o_sel_valid <= 1'b0;
            last_idx    <= IDX_W'(ctxmgt_pkg::REQ_WP);  // ceu goes first
        end else if (o_sel_valid) begin
            if (i_receive) begin
                o_sel_valid <= 1'b0;   // repick next cycle on fresh empties
            end
        end else if (i_init_finish && (nxt_sel != '0)) begin
            o_sel       <= nxt_sel;
            o_sel_valid <= 1'b1;
            last_idx    <= nxt_idx;
        end
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        o_sel_valid |-> $onehot(o_sel))
        else $error("scheduler selection is not one-hot");

endmodule

// ==== hdl/ctxmgt_top.sv ====
// ceu ready stays low and no command is popped until the clear sweep is done
`timescale 1ns/10ps

module ctxmgt_top #(
    parameter int QPN_W = ctxmgt_pkg::QPN_W_DEF
) (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  o_init_finish,
    // ceu request and completion
    input  logic                  i_ceu_valid,
    input  ctxmgt_pkg::ceu_req_t  i_ceu_req,
    output logic                  o_ceu_ready,
    output logic                  o_cpl_valid,
    output ctxmgt_pkg::ceu_cpl_t  o_cpl,
    input  logic                  i_cpl_ready,
    // doorbell channel
    input  logic                  i_db_cmd_empty,
    input  ctxmgt_pkg::eng_cmd_t  i_db_cmd,
    output logic                  o_db_cmd_rd_en,
    input  logic                  i_db_rsp_prog_full,
    output logic                  o_db_rsp_wr_en,
    output ctxmgt_pkg::eng_rsp_t  o_db_rsp,
    // wqe parser channel
    input  logic                  i_wp_cmd_empty,
    input  ctxmgt_pkg::eng_cmd_t  i_wp_cmd,
    output logic                  o_wp_cmd_rd_en,
    input  logic                  i_wp_rsp_prog_full,
    output logic                  o_wp_rsp_wr_en,
    output ctxmgt_pkg::eng_rsp_t  o_wp_rsp
);

    logic                            kw_rd_en;
    logic                            kw_empty;
    ctxmgt_pkg::key_wr_t             kw_data;
    logic [ctxmgt_pkg::NUM_REQ-1:0]  req_empty;   // per requester slot
    logic [ctxmgt_pkg::NUM_REQ-1:0]  sel;
    logic                            sel_valid;
    logic                            receive;

    assign req_empty[ctxmgt_pkg::REQ_CEU] = kw_empty;
    assign req_empty[ctxmgt_pkg::REQ_DB]  = i_db_cmd_empty;
    assign req_empty[ctxmgt_pkg::REQ_WP]  = i_wp_cmd_empty;

    ceu_parser u_ceu_parser (
        .clk           (clk),
        .rst           (rst),
        .i_init_finish (o_init_finish),
        .i_ceu_valid   (i_ceu_valid),
        .i_ceu_req     (i_ceu_req),
        .o_ceu_ready   (o_ceu_ready),
        .i_kw_rd_en    (kw_rd_en),
        .o_kw_empty    (kw_empty),
        .o_kw_data     (kw_data)
    );

    req_sched u_req_sched (
        .clk           (clk),
        .rst           (rst),
        .i_init_finish (o_init_finish),
        .i_empty       (req_empty),
        .i_receive     (receive),
        .o_sel         (sel),
        .o_sel_valid   (sel_valid)
    );

    key_ctx_table #(.QPN_W(QPN_W)) u_key_ctx_table (
        .clk                (clk),
        .rst                (rst),
        .o_init_finish      (o_init_finish),
        .i_sel              (sel),
        .i_sel_valid        (sel_valid),
        .o_receive          (receive),
        .i_kw_data          (kw_data),
        .o_kw_rd_en         (kw_rd_en),
        .i_db_cmd_empty     (i_db_cmd_empty),
        .i_db_cmd           (i_db_cmd),
        .o_db_cmd_rd_en     (o_db_cmd_rd_en),
        .i_db_rsp_prog_full (i_db_rsp_prog_full),
        .o_db_rsp_wr_en     (o_db_rsp_wr_en),
        .o_db_rsp           (o_db_rsp),
        .i_wp_cmd_empty     (i_wp_cmd_empty),
        .i_wp_cmd           (i_wp_cmd),
        .o_wp_cmd_rd_en     (o_wp_cmd_rd_en),
        .i_wp_rsp_prog_full (i_wp_rsp_prog_full),
        .o_wp_rsp_wr_en     (o_wp_rsp_wr_en),
        .o_wp_rsp           (o_wp_rsp),
        .o_cpl_valid        (o_cpl_valid),
        .o_cpl              (o_cpl),
        .i_cpl_ready        (i_cpl_ready)
    );

endmodule

// ==== tests/tb_clkgen.sv ====
// free running clock, starts low, period given in ns
`timescale 1ns/10ps

module tb_clkgen #(
    parameter real PERIOD_NS = 100.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) o_clk = ~o_clk;   // half period per phase
        end
    end

endmodule

// ==== tests/tb_ctxmgt.sv ====
// trace is opened as tests/ctxmgt_trace.txt, so run from the project root; QPN_W is fixed at 8
`timescale 1ns/10ps

module tb_ctxmgt;

    localparam int QPN_W       = 8;
    localparam int RST_CYCLES  = 16;
    localparam int TIMEOUT     = 2000;                 // cycles allowed per wait
    localparam int INIT_CYCLES = (1 << QPN_W) + 1;     // sweep plus flag register

    logic                  clk;
    logic                  rst;
    logic                  init_finish;
    logic                  ceu_valid;
    ctxmgt_pkg::ceu_req_t  ceu_req;
    logic                  ceu_ready;
    logic                  cpl_valid;
    ctxmgt_pkg::ceu_cpl_t  cpl;
    logic                  cpl_ready;
    logic                  db_cmd_empty;
    ctxmgt_pkg::eng_cmd_t  db_cmd;
    logic                  db_cmd_rd_en;
    logic                  db_rsp_prog_full;
    logic                  db_rsp_wr_en;
    ctxmgt_pkg::eng_rsp_t  db_rsp;
    logic                  wp_cmd_empty;
    ctxmgt_pkg::eng_cmd_t  wp_cmd;
    logic                  wp_cmd_rd_en;
    logic                  wp_rsp_prog_full;
    logic                  wp_rsp_wr_en;
    ctxmgt_pkg::eng_rsp_t  wp_rsp;

    // command fifo models and expected responses, per channel
    ctxmgt_pkg::eng_cmd_t  db_q[$];
    ctxmgt_pkg::eng_cmd_t  wp_q[$];
    ctxmgt_pkg::eng_rsp_t  db_exp[$];
    ctxmgt_pkg::eng_rsp_t  wp_exp[$];

    bit db_pop     = 1'b0;   // pop seen at negedge, applied after next edge
    bit wp_pop     = 1'b0;
    int db_hold    = 0;      // forced prog_full cycles left
    int wp_hold    = 0;
    int db_cmd_cnt = 0;
    int wp_cmd_cnt = 0;
    int db_rsp_cnt = 0;
    int wp_rsp_cnt = 0;
    int cpl_exp    = 0;
    int cpl_seen   = 0;
    int section    = 1;      // bumped at every barrier
    int checks     = 0;
    int errors     = 0;
    int timeouts   = 0;
    bit stop_run   = 1'b0;   // set by a timeout, unwinds every loop

    tb_clkgen #(.PERIOD_NS(100.0)) u_tb_clkgen (.o_clk(clk));

    ctxmgt_top #(.QPN_W(QPN_W)) u_ctxmgt_top (
        .clk                (clk),
        .rst                (rst),
        .o_init_finish      (init_finish),
        .i_ceu_valid        (ceu_valid),
        .i_ceu_req          (ceu_req),
        .o_ceu_ready        (ceu_ready),
        .o_cpl_valid        (cpl_valid),
        .o_cpl              (cpl),
        .i_cpl_ready        (cpl_ready),
        .i_db_cmd_empty     (db_cmd_empty),
        .i_db_cmd           (db_cmd),
        .o_db_cmd_rd_en     (db_cmd_rd_en),
        .i_db_rsp_prog_full (db_rsp_prog_full),
        .o_db_rsp_wr_en     (db_rsp_wr_en),
        .o_db_rsp           (db_rsp),
        .i_wp_cmd_empty     (wp_cmd_empty),
        .i_wp_cmd           (wp_cmd),
        .o_wp_cmd_rd_en     (wp_cmd_rd_en),
        .i_wp_rsp_prog_full (wp_rsp_prog_full),
        .o_wp_rsp_wr_en     (wp_rsp_wr_en),
        .o_wp_rsp           (wp_rsp)
    );

    // ------------------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------------------
    function automatic string test_name(input string what);
        return $sformatf("sec%0d/%s", section, what);
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp)
            else begin
                errors++;
                $display("** Error %s: expected %h, actual %h", test_name(what), exp, act);
            end
    endtask

    task automatic report_fail(input string msg);
        errors++;
        $display("Error in section %0d: %s", section, msg);
    endtask

    task automatic timeout_hit(input string msg);
        timeouts++;
        stop_run = 1'b1;
        $display("Timeout in section %0d: %s", section, msg);
    endtask

    // ------------------------------------------------------------------------
    // fifo models and input drive, 1 ns after the rising edge
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        #1;
        if (db_pop && db_q.size() > 0) db_q.delete(0);
        if (wp_pop && wp_q.size() > 0) wp_q.delete(0);
        db_pop = 1'b0;
        wp_pop = 1'b0;
        db_cmd_empty = (db_q.size() == 0);
        db_cmd       = (db_q.size() > 0) ? db_q[0] : '0;   // fall-through head
        wp_cmd_empty = (wp_q.size() == 0);
        wp_cmd       = (wp_q.size() > 0) ? wp_q[0] : '0;
        if (db_hold > 0) db_hold--;
        if (wp_hold > 0) wp_hold--;
        // forced hold plus random back pressure, one in four
        db_rsp_prog_full = (db_hold > 0) || (($urandom & 32'h3) == 32'h0);
        wp_rsp_prog_full = (wp_hold > 0) || (($urandom & 32'h3) == 32'h0);
        cpl_ready        = (($urandom & 32'h1) != 32'h0);
    end

    // ------------------------------------------------------------------------
    // monitor, outputs sampled at the falling edge
    // ------------------------------------------------------------------------
    task automatic check_rsp(input bit ch, input ctxmgt_pkg::eng_rsp_t got);
        ctxmgt_pkg::eng_rsp_t exp;
        string                name;
        int                   left;
        name = ch ? "wp" : "db";
        left = ch ? wp_exp.size() : db_exp.size();
        assert (left > 0) else report_fail({name, " response arrived with none outstanding"});
        if (left > 0) begin
            exp = ch ? wp_exp.pop_front() : db_exp.pop_front();   // command order
            check_val({name, "_rsp_tag"}, 64'(exp.tag), 64'(got.tag));
            check_val({name, "_rsp_qpn"}, 64'(exp.qpn), 64'(got.qpn));
            check_val({name, "_rsp_ctx"}, exp.ctx, got.ctx);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (!init_finish) begin
                assert (!ceu_ready && !db_cmd_rd_en && !wp_cmd_rd_en && !db_rsp_wr_en &&
                        !wp_rsp_wr_en && !cpl_valid)
                    else report_fail("ready, rd_en, wr_en or valid active before init finished");
            end
            assert (!(db_rsp_wr_en && db_rsp_prog_full))
                else report_fail("doorbell response written while prog_full was high");
            assert (!(wp_rsp_wr_en && wp_rsp_prog_full))
                else report_fail("wqe parser response written while prog_full was high");
            if (db_cmd_rd_en) begin
                assert (db_q.size() > 0) else report_fail("doorbell command FIFO popped empty");
                db_pop = 1'b1;
            end
            if (wp_cmd_rd_en) begin
                assert (wp_q.size() > 0) else report_fail("wqe parser command FIFO popped empty");
                wp_pop = 1'b1;
            end
            if (db_rsp_wr_en) begin
                db_rsp_cnt++;
                check_rsp(1'b0, db_rsp);
            end
            if (wp_rsp_wr_en) begin
                wp_rsp_cnt++;
                check_rsp(1'b1, wp_rsp);
            end
            if (cpl_valid && cpl_ready) cpl_seen++;   // handshake lands next edge
        end
    end

    // ------------------------------------------------------------------------
    // trace operations
    // ------------------------------------------------------------------------
    task automatic check_init();
        int cycles;
        cycles = 0;
        @(negedge clk);   // this one still falls before the first edge out of reset
        while (!init_finish && cycles < TIMEOUT && !stop_run) begin
            @(negedge clk);
            cycles++;
        end
        if (init_finish) check_val("init_cycles", 64'(INIT_CYCLES), 64'(cycles));
        else if (!stop_run) timeout_hit("init_finish never rose");
    endtask

    task automatic ceu_write(input ctxmgt_pkg::ceu_op_e op, input ctxmgt_pkg::qpn_t qpn,
                             input ctxmgt_pkg::ctx_t ctx);
        int cycles;
        bit done;
        cycles = 0;
        done   = 1'b0;
        @(posedge clk);
        #1;
        ceu_valid = 1'b1;
        ceu_req   = '{op: op, qpn: qpn, ctx: ctx};
        while (!done && cycles < TIMEOUT && !stop_run) begin
            @(negedge clk);
            cycles++;
            done = ceu_ready;
        end
        if (done) begin
            @(posedge clk);   // transfer edge
            #1;
        end else if (!stop_run) begin
            timeout_hit("CEU request never accepted");
        end
        ceu_valid = 1'b0;
        // reserved codes are dropped without a completion
        if (done && (op == ctxmgt_pkg::CEU_WR_CTX || op == ctxmgt_pkg::CEU_CLR_CTX)) begin
            cpl_exp++;
            done   = 1'b0;
            cycles = 0;
            while (!done && cycles < TIMEOUT && !stop_run) begin
                @(negedge clk);
                cycles++;
                done = cpl_valid && cpl_ready;
            end
            if (done) begin
                check_val("cpl_qpn", 64'(qpn), 64'(cpl.qpn));
                check_val("cpl_op", 64'(op), 64'(cpl.op));
            end else if (!stop_run) begin
                timeout_hit("no CEU completion");
            end
        end
    endtask

    task automatic queue_read(input bit ch, input ctxmgt_pkg::qpn_t qpn,
                              input ctxmgt_pkg::tag_t tag, input ctxmgt_pkg::ctx_t ctx);
        ctxmgt_pkg::eng_cmd_t cmd;
        ctxmgt_pkg::eng_rsp_t rsp;
        cmd = '{tag: tag, qpn: qpn};
        rsp = '{tag: tag, qpn: qpn, ctx: ctx};   // full qpn echoed
        @(negedge clk);
        if (ch) begin
            wp_q.push_back(cmd);
            wp_exp.push_back(rsp);
            wp_cmd_cnt++;
        end else begin
            db_q.push_back(cmd);
            db_exp.push_back(rsp);
            db_cmd_cnt++;
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while ((db_exp.size() > 0 || wp_exp.size() > 0 || cpl_seen < cpl_exp) &&
               cycles < TIMEOUT && !stop_run) begin
            @(negedge clk);
            cycles++;
        end
        if ((db_exp.size() > 0 || wp_exp.size() > 0 || cpl_seen < cpl_exp) && !stop_run) begin
            timeout_hit("responses or completions still outstanding at barrier");
        end
        check_val("cpl_count", 64'(cpl_exp), 64'(cpl_seen));
    endtask

    task automatic run_trace();
        int          fd;
        string       line;
        byte         kind;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        logic [63:0] d;
        fd = $fopen("tests/ctxmgt_trace.txt", "r");
        if (fd == 0) begin
            report_fail("cannot open trace file");
            stop_run = 1'b1;
        end
        while (fd != 0 && !stop_run && $fgets(line, fd) > 0) begin
            kind = line.getc(0);
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d));
            case (kind)
                "W": ceu_write(ctxmgt_pkg::ceu_op_e'(a[1:0]), b[31:0], c);
                "R": queue_read(a[0], b[31:0], c[7:0], d);
                "P": begin
                    @(negedge clk);
                    if (a[0]) wp_hold = int'(b[15:0]);
                    else db_hold = int'(b[15:0]);
                end
                "B": begin
                    wait_idle();
                    section++;
                end
                default: ;   // comments and blank lines
            endcase
        end
        if (fd != 0) $fclose(fd);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'hdcc5));
        rst              = 1'b1;
        ceu_valid        = 1'b0;
        ceu_req          = '0;
        cpl_ready        = 1'b0;
        db_cmd_empty     = 1'b1;
        db_cmd           = '0;
        db_rsp_prog_full = 1'b0;
        wp_cmd_empty     = 1'b1;
        wp_cmd           = '0;
        wp_rsp_prog_full = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        // reads get queued during the sweep on purpose
        fork
            check_init();
            run_trace();
        join
        if (!stop_run) wait_idle();
        check_val("db_rsp_count", 64'(db_cmd_cnt), 64'(db_rsp_cnt));
        check_val("wp_rsp_count", 64'(wp_cmd_cnt), 64'(wp_rsp_cnt));
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/ctxmgt_trace.txt ====
# key context trace, one operation per line, all fields hex
# W op qpn ctx | R ch(0 db, 1 wp) qpn tag exp_ctx | P ch hold_cycles | B barrier
R 0 00000005 01 0000000000000000
R 1 000000a3 02 0000000000000000
R 0 000000ff 03 0000000000000000
B
W 1 00000010 1122334455667788
R 0 00000010 11 1122334455667788
R 1 00000010 12 1122334455667788
W 1 00000120 cafef00d00000001
R 1 00000020 13 cafef00d00000001
R 0 7f000120 14 cafef00d00000001
B
W 2 00000010 ffffffffffffffff
R 0 00000010 21 0000000000000000
W 1 00000030 0123456789abcdef
W 0 00000030 deadbeefdeadbeef
W 3 00000030 5555aaaa5555aaaa
R 1 00000030 22 0123456789abcdef
B
P 0 28
R 0 00000030 31 0123456789abcdef
R 0 00000020 32 cafef00d00000001
R 0 00000044 33 0000000000000000
R 0 00000010 34 0000000000000000
P 1 14
R 1 00000030 35 0123456789abcdef
R 1 00000020 36 cafef00d00000001
B
R 0 00000010 51 0000000000000000
R 1 00000020 52 cafef00d00000001
W 1 00000050 0000000000005050
R 0 00000030 53 0123456789abcdef
R 1 00000030 54 0123456789abcdef
W 1 00000060 6060606060606060
R 0 00000050 55 0000000000005050
R 1 00000060 56 6060606060606060
W 2 00000020 0000000000000000
R 0 00000020 57 0000000000000000
R 1 00000010 58 0000000000000000
B

// ==== project.f ====
common/ctxmgt_pkg.sv
key_ctx/key_ctx_ram.sv
key_ctx/key_ctx_table.sv
hdl/ceu_parser.sv
hdl/req_sched.sv
hdl/ctxmgt_top.sv
tests/tb_clkgen.sv
tests/tb_ctxmgt.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_ctxmgt -f project.f

out=$(./obj_dir/Vtb_ctxmgt)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
